// ==== design/board_map_pkg.sv ====
/*
 * board map package
 * I/O port map, memory map constants and the system address word,
 * which is decoded once as an I/O port and once as a memory address
 */
package board_map_pkg;

   // I/O view of the address, only a9:0 reach the port decoder
   typedef struct packed {
      logic [9:0] unused;
      logic [1:0] region;   // a9:8
      logic [2:0] dev_sel;  // a7:5
      logic [4:0] port;
   } io_view_t;

   // memory view of the address
   typedef struct packed {
      logic [3:0]  seg;      // a19:16
      logic [2:0]  rom_blk;  // a15:13, one 8k ROM socket each
      logic [12:0] offset;
   } mem_view_t;

   typedef union packed {
      io_view_t  io_view;
      mem_view_t mem_view;
   } board_addr_t;

   // device codes on a7:5 inside the system region
   localparam logic [2:0] DEV_DMA     = 3'd0;
   localparam logic [2:0] DEV_PIC     = 3'd1;
   localparam logic [2:0] DEV_PIT     = 3'd2;
   localparam logic [2:0] DEV_PPI     = 3'd3;
   localparam logic [2:0] DEV_DMA_PG  = 3'd4;
   localparam logic [2:0] DEV_NMI_REG = 3'd5;

   localparam logic [1:0] IO_SYS_REGION = 2'd0;  // ports 000-0ff
   localparam logic [3:0] ROM_SEG       = 4'hf;  // f0000-fffff
   localparam logic [1:0] RAM_SEG_LIMIT = 2'd0;  // first 256k on the board

   localparam int NMI_MASK_BIT = 7;

endpackage

// ==== design/bus_timing_pkg.sv ====
/*
 * bus timing package
 * clock counts that stand in for the delay line taps,
 * and the state encoding of the DMA hold sequencer
 */
package bus_timing_pkg;

   // counts after RAS start
   localparam logic [2:0] ADDR_SEL_DELAY = 3'd2;
   localparam logic [2:0] CAS_DELAY      = 3'd3;

   localparam logic [2:0] TIMER_MAX = 3'd7;  // counter saturates here

   typedef enum logic [2:0] {
      S_IDLE,
      S_WAIT_BUS,   // hold request seen, bus still busy
      S_HOLD,
      S_AEN,
      S_DMA
   } hold_state_t;

endpackage

// ==== design/mem_cycle_if.sv ====
/*
 * DRAM cycle interface
 * bank select from the decoder and cycle phases from the timer,
 * both consumed by the RAS/CAS strobe generator
 */
`timescale 1ns/100ps

interface mem_cycle_if;

   logic       ram_sel;   // address falls in on-board RAM
   logic       refresh;   // DMA channel 0 refresh cycle
   logic [1:0] bank;
   logic       active;
   logic       addr_sel;
   logic       cas_en;

   modport decode (output ram_sel, refresh, bank);
   modport timer  (output active, addr_sel, cas_en);
   modport strobe (input ram_sel, refresh, bank, active, addr_sel, cas_en);

endinterface

// ==== design/addr_decoder.sv ====
/*
 * address decoder
 * system I/O chip selects, DMA page and NMI register writes,
 * ROM socket selects and the RAM bank for the DRAM strobes
 */
`timescale 1ns/100ps

module addr_decoder (
   input  board_map_pkg::board_addr_t a,
   input  logic                       ior_n,
   input  logic                       iow_n,
   input  logic                       memr_n,
   input  logic                       aen_brd,
   input  logic                       dack0,
   output logic                       dma_cs_n,
   output logic                       intr_cs_n,
   output logic                       tc_cs_n,
   output logic                       ppi_cs_n,
   output logic                       wrt_dma_pg_reg_n,
   output logic                       nmi_reg_wr,
   output logic [7:0]                 rom_cs_n,
   mem_cycle_if.decode                mem
);
   import board_map_pkg::*;

   logic io_sel;
   logic io_wr;
   logic rom_sel;

   // CPU owns the bus and the port is in the system region
   assign io_sel = !aen_brd && (a.io_view.region == IO_SYS_REGION);
   assign io_wr  = io_sel && !iow_n;

   // peripheral chips see their select without a strobe
   assign dma_cs_n  = !(io_sel && (a.io_view.dev_sel == DEV_DMA));
   assign intr_cs_n = !(io_sel && (a.io_view.dev_sel == DEV_PIC));
   assign tc_cs_n   = !(io_sel && (a.io_view.dev_sel == DEV_PIT));
   assign ppi_cs_n  = !(io_sel && (a.io_view.dev_sel == DEV_PPI));

   // write-only registers on the board
   assign wrt_dma_pg_reg_n = !(io_wr && (a.io_view.dev_sel == DEV_DMA_PG));
   assign nmi_reg_wr       = io_wr && (a.io_view.dev_sel == DEV_NMI_REG);

   // memory read only, an I/O read in flight keeps the ROMs off the data bus
   assign rom_sel = !memr_n && ior_n && (a.mem_view.seg == ROM_SEG);

   always_comb begin
      rom_cs_n = 8'hff;
      if (rom_sel) begin
         rom_cs_n[a.mem_view.rom_blk] = 1'b0;  // one socket per 8k block
      end
   end

   assign mem.refresh = dack0;
   assign mem.ram_sel = (a.mem_view.seg[3:2] == RAM_SEG_LIMIT) && !dack0;
   assign mem.bank    = a.mem_view.seg[1:0];  // 64k per bank

endmodule

// ==== design/dma_hold_fsm.sv ====
/*
 * DMA hold sequencer
 * waits for an idle CPU bus after a DMA hold request, then grants
 * hold, enables the board address latches off and the DMA address on
 */
`timescale 1ns/100ps

module dma_hold_fsm (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       hrq_dma,
   input  logic [2:0] s_n,
   input  logic       lock_n,
   output logic       holda,
   output logic       aen_brd,
   output logic       dma_aen_n
);
   import bus_timing_pkg::*;

   hold_state_t state;
   hold_state_t next_state;
   logic        bus_idle;

   // passive status and no locked instruction
   assign bus_idle = (s_n == 3'b111) && lock_n;

   always_comb begin
      next_state = state;
      if (!hrq_dma) begin
         next_state = S_IDLE;  // request dropped, release at once
      end else begin
         case (state)
            S_IDLE:     next_state = S_WAIT_BUS;
            S_WAIT_BUS: begin
               if (bus_idle) begin
                  next_state = S_HOLD;
               end
            end
            S_HOLD:     next_state = S_AEN;
            S_AEN:      next_state = S_DMA;
            S_DMA:      next_state = S_DMA;
            default:    next_state = S_IDLE;
         endcase
      end
   end

   // outputs registered from the next state, so they change with it
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state     <= S_IDLE;
         holda     <= 1'b0;
         aen_brd   <= 1'b0;
         dma_aen_n <= 1'b1;
      end else begin
         state     <= next_state;
         holda     <= next_state inside {S_HOLD, S_AEN, S_DMA};
         aen_brd   <= next_state inside {S_AEN, S_DMA};
         dma_aen_n <= (next_state != S_DMA);
      end
   end

endmodule

// ==== design/mem_cycle_timer.sv ====
/*
 * memory cycle timer
 * counts clocks from the start of a memory strobe and marks
 * the address mux switch and the CAS point of the DRAM cycle
 */
`timescale 1ns/100ps

module mem_cycle_timer (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       memr_n,
   input  logic       memw_n,
   mem_cycle_if.timer mem
);
   import bus_timing_pkg::*;

   logic       rasc;
   logic       active_q;
   logic [2:0] count;

   assign rasc = !memr_n || !memw_n;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         active_q <= 1'b0;
         count    <= 3'd0;
      end else if (!rasc) begin
         active_q <= 1'b0;  // strobe gone, cycle over
         count    <= 3'd0;
      end else begin
         active_q <= 1'b1;
         if (active_q && (count != TIMER_MAX)) begin
            count <= count + 3'd1;
         end
      end
   end

   assign mem.active   = active_q;
   assign mem.addr_sel = active_q && (count >= ADDR_SEL_DELAY);  // row to column
   assign mem.cas_en   = active_q && (count >= CAS_DELAY);

endmodule

// ==== design/ram_strobe_gen.sv ====
/*
 * RAS/CAS strobe generator
 * registered active-low row and column strobes for four DRAM banks,
 * all rows at once during refresh, plus the registered address mux select
 */
`timescale 1ns/100ps

module ram_strobe_gen (
   input  logic        clk,
   input  logic        reset_n,
   mem_cycle_if.strobe mem,
   output logic [3:0]  ras_n,
   output logic [3:0]  cas_n,
   output logic        addr_sel
);

   logic [3:0] bank_hot;

   assign bank_hot = 4'b0001 << mem.bank;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ras_n    <= 4'hf;
         cas_n    <= 4'hf;
         addr_sel <= 1'b0;
      end else begin
         if (mem.active && mem.refresh) begin
            ras_n <= 4'h0;  // RAS-only refresh of every bank
         end else if (mem.active && mem.ram_sel) begin
            ras_n <= ~bank_hot;
         end else begin
            ras_n <= 4'hf;
         end

         // no column strobe during refresh
         if (mem.cas_en && mem.ram_sel && !mem.refresh) begin
            cas_n <= ~bank_hot;
         end else begin
            cas_n <= 4'hf;
         end

         addr_sel <= mem.addr_sel;
      end
   end

endmodule

// ==== design/nmi_wait_ctrl.sv ====
/*
 * NMI and wait-state control
 * NMI mask register written from d7, gating of parity and channel
 * check errors, and one wait state at the start of each bus strobe
 */
`timescale 1ns/100ps

module nmi_wait_ctrl (
   input  logic       clk,
   input  logic       reset_n,
   input  logic [7:0] d,
   input  logic       nmi_reg_wr,
   input  logic       ior_n,
   input  logic       iow_n,
   input  logic       memr_n,
   input  logic       io_ch_rdy,
   input  logic       parity_chk,
   input  logic       io_ch_ck,
   output logic       ready,
   output logic       nmi
);
   import board_map_pkg::*;

   logic ior_q;
   logic iow_q;
   logic memr_q;
   logic strobe_fall;
   logic allow_nmi;

   // high for the cycle in which any strobe has just gone low
   assign strobe_fall = (ior_q && !ior_n) || (iow_q && !iow_n) || (memr_q && !memr_n);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ior_q     <= 1'b1;
         iow_q     <= 1'b1;
         memr_q    <= 1'b1;
         ready     <= 1'b1;
         allow_nmi <= 1'b0;
         nmi       <= 1'b0;
      end else begin
         ior_q  <= ior_n;
         iow_q  <= iow_n;
         memr_q <= memr_n;
         ready  <= !strobe_fall && io_ch_rdy;  // channel can stretch the wait
         if (nmi_reg_wr) begin
            allow_nmi <= d[NMI_MASK_BIT];
         end
         nmi <= allow_nmi && (parity_chk || io_ch_ck);
      end
   end

endmodule

// ==== design/pc_board_ctrl.sv ====
/*
 * system board control
 * address decoding, DMA hold, DRAM cycle timing and strobes,
 * wait state and NMI logic of the PC system board on one clock
 */
`timescale 1ns/100ps

module pc_board_ctrl (
   input  logic        clk,
   input  logic        reset_n,
   input  logic [19:0] a,
   input  logic [7:0]  d,
   input  logic        ior_n,
   input  logic        iow_n,
   input  logic        memr_n,
   input  logic        memw_n,
   input  logic [2:0]  s_n,
   input  logic        lock_n,
   input  logic        hrq_dma,
   input  logic        dack0,
   input  logic        io_ch_rdy,
   input  logic        parity_chk,
   input  logic        io_ch_ck,
   output logic        holda,
   output logic        aen_brd,
   output logic        dma_aen_n,
   output logic        ready,
   output logic        nmi,
   output logic        dma_cs_n,
   output logic        intr_cs_n,
   output logic        tc_cs_n,
   output logic        ppi_cs_n,
   output logic        wrt_dma_pg_reg_n,
   output logic [7:0]  rom_cs_n,
   output logic [3:0]  ras_n,
   output logic [3:0]  cas_n,
   output logic        addr_sel
);
   import board_map_pkg::*;

   board_addr_t sys_addr;
   logic        nmi_reg_wr;

   mem_cycle_if mem_bus ();

   assign sys_addr = board_addr_t'(a);

   dma_hold_fsm i_dma_hold_fsm (
      .clk       (clk),
      .reset_n   (reset_n),
      .hrq_dma   (hrq_dma),
      .s_n       (s_n),
      .lock_n    (lock_n),
      .holda     (holda),
      .aen_brd   (aen_brd),
      .dma_aen_n (dma_aen_n)
   );

   addr_decoder i_addr_decoder (
      .a                (sys_addr),
      .ior_n            (ior_n),
      .iow_n            (iow_n),
      .memr_n           (memr_n),
      .aen_brd          (aen_brd),  // DMA owns the bus, no CPU port decode
      .dack0            (dack0),
      .dma_cs_n         (dma_cs_n),
      .intr_cs_n        (intr_cs_n),
      .tc_cs_n          (tc_cs_n),
      .ppi_cs_n         (ppi_cs_n),
      .wrt_dma_pg_reg_n (wrt_dma_pg_reg_n),
      .nmi_reg_wr       (nmi_reg_wr),
      .rom_cs_n         (rom_cs_n),
      .mem              (mem_bus.decode)
   );

   mem_cycle_timer i_mem_cycle_timer (
      .clk     (clk),
      .reset_n (reset_n),
      .memr_n  (memr_n),
      .memw_n  (memw_n),
      .mem     (mem_bus.timer)
   );

   ram_strobe_gen i_ram_strobe_gen (
      .clk      (clk),
      .reset_n  (reset_n),
      .mem      (mem_bus.strobe),
      .ras_n    (ras_n),
      .cas_n    (cas_n),
      .addr_sel (addr_sel)
   );

   nmi_wait_ctrl i_nmi_wait_ctrl (
      .clk        (clk),
      .reset_n    (reset_n),
      .d          (d),
      .nmi_reg_wr (nmi_reg_wr),
      .ior_n      (ior_n),
      .iow_n      (iow_n),
      .memr_n     (memr_n),
      .io_ch_rdy  (io_ch_rdy),
      .parity_chk (parity_chk),
      .io_ch_ck   (io_ch_ck),
      .ready      (ready),
      .nmi        (nmi)
   );

endmodule

// ==== verification/tb_clock_gen.sv ====
/*
 * testbench clock and reset
 * 50 MHz clock, synchronous active-low reset held for 16 cycles
 */
`timescale 1ns/100ps

module tb_clock_gen (
   output logic clk,
   output logic reset_n
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns period
   end

   initial begin
      reset_n = 1'b0;
      repeat (16) @(posedge clk);
      #2 reset_n = 1'b1;  // released on the stimulus offset
   end

endmodule

// ==== verification/pc_board_ctrl_tb.sv ====
/*
 * system board control testbench
 * random I/O and memory accesses against a reference decode,
 * DRAM cycle and refresh timing, DMA hold sequence, NMI mask and wait state
 */
`timescale 1ns/100ps

module pc_board_ctrl_tb;
   import board_map_pkg::*;
   import bus_timing_pkg::*;

   localparam int IO_COUNT      = 600;
   localparam int AEN_COUNT     = 200;
   localparam int ROM_COUNT     = 200;
   localparam int RAM_COUNT     = 16;
   localparam int REFRESH_COUNT = 4;
   localparam int CYCLE_LEN     = 8;  // edges watched per DRAM cycle
   localparam int CYCLE_HOLD    = 5;  // edges the memory strobe stays low
   // reset, access loops, DRAM cycles and fixed sequences, then doubled
   localparam int RUN_CYCLES = 16 + IO_COUNT + AEN_COUNT + 2 * ROM_COUNT
                              + (CYCLE_LEN + 1) * (RAM_COUNT + REFRESH_COUNT) + 100;
   localparam int MAX_CYCLES = 2 * RUN_CYCLES;

   logic        clk;
   logic        reset_n;
   logic [19:0] a;
   logic [7:0]  d;
   logic        ior_n;
   logic        iow_n;
   logic        memr_n;
   logic        memw_n;
   logic [2:0]  s_n;
   logic        lock_n;
   logic        hrq_dma;
   logic        dack0;
   logic        io_ch_rdy;
   logic        parity_chk;
   logic        io_ch_ck;
   logic        holda;
   logic        aen_brd;
   logic        dma_aen_n;
   logic        ready;
   logic        nmi;
   logic        dma_cs_n;
   logic        intr_cs_n;
   logic        tc_cs_n;
   logic        ppi_cs_n;
   logic        wrt_dma_pg_reg_n;
   logic [7:0]  rom_cs_n;
   logic [3:0]  ras_n;
   logic [3:0]  cas_n;
   logic        addr_sel;

   int          err_count   = 0;
   int          check_count = 0;
   int          test_count  = 0;
   int          test_errs   = 0;
   int          cycle_count = 0;
   logic [31:0] lfsr;
   logic        cmp_en;
   logic        aen_exp;  // expected bus owner for the decode check
   logic [14:0] cmp_exp;

   tb_clock_gen i_clock_gen (.clk(clk), .reset_n(reset_n));

   pc_board_ctrl i_dut (
      .clk(clk), .reset_n(reset_n), .a(a), .d(d),
      .ior_n(ior_n), .iow_n(iow_n), .memr_n(memr_n), .memw_n(memw_n),
      .s_n(s_n), .lock_n(lock_n), .hrq_dma(hrq_dma), .dack0(dack0),
      .io_ch_rdy(io_ch_rdy), .parity_chk(parity_chk), .io_ch_ck(io_ch_ck),
      .holda(holda), .aen_brd(aen_brd), .dma_aen_n(dma_aen_n),
      .ready(ready), .nmi(nmi),
      .dma_cs_n(dma_cs_n), .intr_cs_n(intr_cs_n), .tc_cs_n(tc_cs_n),
      .ppi_cs_n(ppi_cs_n), .wrt_dma_pg_reg_n(wrt_dma_pg_reg_n),
      .rom_cs_n(rom_cs_n), .ras_n(ras_n), .cas_n(cas_n), .addr_sel(addr_sel)
   );

   // x^32 + x^22 + x^2 + x + 1, shifted right
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // {bank, dma, intr, tc, ppi, dma page, rom[7:0]} from the board map
   function automatic logic [14:0] decode_ref(input logic [19:0] addr, input logic iow,
                                              input logic memr, input logic aen);
      logic       io_ok;
      logic [2:0] dev;
      logic [7:0] rom;
      io_ok = !aen && (addr[9:8] == IO_SYS_REGION);
      dev   = addr[7:5];
      rom   = 8'hff;
      if (!memr && (addr[19:16] == ROM_SEG))
         rom[addr[15:13]] = 1'b0;
      return {addr[17:16],
              !(io_ok && dev == DEV_DMA), !(io_ok && dev == DEV_PIC),
              !(io_ok && dev == DEV_PIT), !(io_ok && dev == DEV_PPI),
              !(io_ok && !iow && dev == DEV_DMA_PG), rom};
   endfunction

   // {ras_n, cas_n, addr_sel} seen after edge n of a DRAM cycle
   function automatic logic [8:0] cycle_ref(input int n, input int hold,
                                            input logic [1:0] bank, input logic refresh);
      logic [3:0] ras;
      logic [3:0] cas;
      logic [3:0] hot;
      logic       sel;
      int         cnt;
      ras = 4'hf;
      cas = 4'hf;
      sel = 1'b0;
      hot = 4'b0001 << bank;
      cnt = n - 2;  // timer count one edge earlier
      // active on edges 1..hold, strobes registered one edge later
      if (n >= 2 && n <= hold + 1) begin
         ras = refresh ? 4'h0 : ~hot;
         if (cnt >= int'(ADDR_SEL_DELAY))
            sel = 1'b1;
         if (!refresh && cnt >= int'(CAS_DELAY))
            cas = ~hot;
      end
      return {ras, cas, sel};
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
      check_count++;
      if (got !== want) begin
         err_count++;
         $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
      end
   endtask

   task automatic next_drive();
      @(posedge clk);
      #2;
   endtask

   task automatic finish_test(input string name);
      test_count++;
      $display("test %-14s done, %0d errors", name, err_count - test_errs);
      test_errs = err_count;
   endtask

   task automatic mem_cycle(input logic [19:0] addr, input logic refresh, input logic write);
      logic [14:0] dec;
      logic [8:0]  want;
      dec = decode_ref(addr, 1'b1, 1'b1, 1'b0);
      next_drive();
      a     = addr;
      dack0 = refresh;
      if (write)
         memw_n = 1'b0;
      else
         memr_n = 1'b0;
      for (int n = 1; n <= CYCLE_LEN; n++) begin
         next_drive();
         if (n == CYCLE_HOLD) begin
            memr_n = 1'b1;
            memw_n = 1'b1;
         end
         if (n == CYCLE_LEN)
            dack0 = 1'b0;
         @(negedge clk);
         want = cycle_ref(n, CYCLE_HOLD, dec[14:13], refresh);
         check("ras_n", 32'(ras_n), 32'(want[8:5]));
         check("cas_n", 32'(cas_n), 32'(want[4:1]));
         check("addr_sel", 32'(addr_sel), 32'(want[0]));
      end
   endtask

   task automatic io_accesses(input int count);
      logic [31:0] r;
      for (int i = 0; i < count; i++) begin
         take_bits(22, r);
         next_drive();
         a = r[19:0];
         if (r[20])
            a[9:8] = IO_SYS_REGION;  // hit the system ports more often
         ior_n  = r[21];
         iow_n  = !r[21];
         cmp_en = 1'b1;
      end
      next_drive();
      cmp_en = 1'b0;
      ior_n  = 1'b1;
      iow_n  = 1'b1;
   endtask

   task automatic reset_values();
      @(negedge clk);
      check("holda", 32'(holda), 32'd0);
      check("aen_brd", 32'(aen_brd), 32'd0);
      check("dma_aen_n", 32'(dma_aen_n), 32'd1);
      check("ras_n", 32'(ras_n), 32'hf);
      check("cas_n", 32'(cas_n), 32'hf);
      check("addr_sel", 32'(addr_sel), 32'd0);
      check("ready", 32'(ready), 32'd1);
      check("nmi", 32'(nmi), 32'd0);
   endtask

   task automatic io_decoding();
      int lat;
      io_accesses(IO_COUNT);
      hrq_dma = 1'b1;  // bus is idle, DMA takes it
      lat = 0;
      do begin
         next_drive();
         @(negedge clk);
         lat++;
      end while (!aen_brd && lat < 10);
      if (!aen_brd) begin
         err_count++;
         $display("bus grant for DMA never raised aen_brd");
      end
      aen_exp = 1'b1;
      io_accesses(AEN_COUNT);
      hrq_dma = 1'b0;
      aen_exp = 1'b0;
      next_drive();
      next_drive();
   endtask

   task automatic rom_reads();
      logic [31:0] r;
      for (int i = 0; i < ROM_COUNT; i++) begin
         take_bits(22, r);
         next_drive();
         a = r[19:0];
         if (r[21:20] != 2'b00)
            a[19:16] = ROM_SEG;
         memr_n = 1'b0;
         cmp_en = 1'b1;
         next_drive();
         memr_n = 1'b1;
      end
      next_drive();
      cmp_en = 1'b0;
   endtask

   task automatic dram_cycles();
      logic [31:0] r;
      for (int i = 0; i < RAM_COUNT; i++) begin
         take_bits(19, r);
         mem_cycle({2'b00, r[17:0]}, 1'b0, r[18]);
      end
   endtask

   task automatic refresh_cycles();
      logic [31:0] r;
      for (int i = 0; i < REFRESH_COUNT; i++) begin
         take_bits(20, r);
         mem_cycle(r[19:0], 1'b1, 1'b0);
      end
   endtask

   task automatic dma_hold();
      int lat;
      next_drive();
      s_n     = 3'b100;  // CPU bus cycle in progress
      hrq_dma = 1'b1;
      repeat (3) begin
         next_drive();
         @(negedge clk);
         check("holda", 32'(holda), 32'd0);
      end
      next_drive();
      s_n    = 3'b111;
      lock_n = 1'b0;  // passive but locked
      repeat (3) begin
         @(negedge clk);
         check("holda", 32'(holda), 32'd0);
         next_drive();
      end
      lock_n = 1'b1;
      @(negedge clk);
      check("holda", 32'(holda), 32'd0);
      lat = 0;
      do begin
         next_drive();
         @(negedge clk);
         lat++;
      end while (!holda && lat < 10);
      if (!holda) begin
         err_count++;
         $display("holda never rose after the bus went idle");
      end
      check("holda_delay", lat, 32'd1);
      check("aen_brd", 32'(aen_brd), 32'd0);
      next_drive();
      @(negedge clk);
      check("aen_brd", 32'(aen_brd), 32'd1);
      check("dma_aen_n", 32'(dma_aen_n), 32'd1);
      next_drive();
      @(negedge clk);
      check("dma_aen_n", 32'(dma_aen_n), 32'd0);
      next_drive();
      hrq_dma = 1'b0;
      @(negedge clk);
      check("holda", 32'(holda), 32'd1);
      next_drive();
      @(negedge clk);
      check("holda", 32'(holda), 32'd0);
      check("aen_brd", 32'(aen_brd), 32'd0);
      check("dma_aen_n", 32'(dma_aen_n), 32'd1);
   endtask

   task automatic nmi_and_wait();
      logic [31:0] r;
      take_bits(12, r);
      next_drive();
      parity_chk = 1'b1;  // mask still clear from reset
      repeat (3) begin
         next_drive();
         @(negedge clk);
         check("nmi", 32'(nmi), 32'd0);
      end
      next_drive();
      parity_chk = 1'b0;
      a     = {10'h000, IO_SYS_REGION, DEV_NMI_REG, r[4:0]};
      d     = {1'b1, r[11:5]};
      iow_n = 1'b0;
      next_drive();
      iow_n    = 1'b1;
      io_ch_ck = 1'b1;
      next_drive();
      io_ch_ck = 1'b0;
      @(negedge clk);
      check("nmi", 32'(nmi), 32'd1);
      next_drive();
      parity_chk = 1'b1;
      @(negedge clk);
      check("nmi", 32'(nmi), 32'd0);
      next_drive();
      parity_chk = 1'b0;
      @(negedge clk);
      check("nmi", 32'(nmi), 32'd1);
      next_drive();
      d     = {1'b0, r[11:5]};  // mask off again
      iow_n = 1'b0;
      next_drive();
      iow_n      = 1'b1;
      parity_chk = 1'b1;
      io_ch_ck   = 1'b1;
      repeat (2) begin
         next_drive();
         @(negedge clk);
         check("nmi", 32'(nmi), 32'd0);
      end
      next_drive();
      parity_chk = 1'b0;
      io_ch_ck   = 1'b0;
      a = '0;
      d = '0;

      // one wait state per strobe fall
      for (int s = 0; s < 3; s++) begin
         next_drive();
         ior_n  = (s != 0);
         iow_n  = (s != 1);
         memr_n = (s != 2);
         next_drive();
         @(negedge clk);
         check("ready", 32'(ready), 32'd0);
         next_drive();
         ior_n  = 1'b1;
         iow_n  = 1'b1;
         memr_n = 1'b1;
         @(negedge clk);
         check("ready", 32'(ready), 32'd1);
      end
      next_drive();
      memr_n    = 1'b0;
      io_ch_rdy = 1'b0;  // channel stretches the cycle
      for (int n = 1; n <= 3; n++) begin
         next_drive();
         if (n == 3)
            io_ch_rdy = 1'b1;
         @(negedge clk);
         check("ready", 32'(ready), 32'd0);
      end
      next_drive();
      @(negedge clk);
      check("ready", 32'(ready), 32'd1);
      next_drive();
      memr_n = 1'b1;
   endtask

   // decode outputs against the reference
   always @(negedge clk) begin
      if (cmp_en) begin
         cmp_exp = decode_ref(a, iow_n, memr_n, aen_exp);
         check("aen_brd", 32'(aen_brd), 32'(aen_exp));
         check("dma_cs_n", 32'(dma_cs_n), 32'(cmp_exp[12]));
         check("intr_cs_n", 32'(intr_cs_n), 32'(cmp_exp[11]));
         check("tc_cs_n", 32'(tc_cs_n), 32'(cmp_exp[10]));
         check("ppi_cs_n", 32'(ppi_cs_n), 32'(cmp_exp[9]));
         check("wrt_dma_pg_reg_n", 32'(wrt_dma_pg_reg_n), 32'(cmp_exp[8]));
         check("rom_cs_n", 32'(rom_cs_n), 32'(cmp_exp[7:0]));
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   initial begin
      a          = '0;
      d          = '0;
      ior_n      = 1'b1;
      iow_n      = 1'b1;
      memr_n     = 1'b1;
      memw_n     = 1'b1;
      s_n        = 3'b111;
      lock_n     = 1'b1;
      hrq_dma    = 1'b0;
      dack0      = 1'b0;
      io_ch_rdy  = 1'b1;
      parity_chk = 1'b0;
      io_ch_ck   = 1'b0;
      cmp_en     = 1'b0;
      aen_exp    = 1'b0;
      lfsr       = 32'h6f51_6aea;

      wait (reset_n === 1'b1);
      reset_values();
      finish_test("reset values");
      io_decoding();
      finish_test("io decoding");
      rom_reads();
      finish_test("rom reads");
      dram_cycles();
      finish_test("dram cycles");
      refresh_cycles();
      finish_test("refresh");
      dma_hold();
      finish_test("dma hold");
      nmi_and_wait();
      finish_test("nmi and wait");

      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
design/board_map_pkg.sv
design/bus_timing_pkg.sv
design/mem_cycle_if.sv
design/addr_decoder.sv
design/dma_hold_fsm.sv
design/mem_cycle_timer.sv
design/ram_strobe_gen.sv
design/nmi_wait_ctrl.sv
design/pc_board_ctrl.sv
verification/tb_clock_gen.sv
verification/pc_board_ctrl_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing
TOP       = pc_board_ctrl_tb
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
